//--- hdl/par_pkg.sv
`default_nettype none

package par_pkg;

	// Worker cores sharing one loop
	localparam int N_CORE = 4;

	// Loop index and stride, both signed
	localparam int IDX_WIDTH = 32;

	// Iteration count from the host
	localparam int CNT_WIDTH = 12;

	// Partial and total sums wrap modulo 2^32
	localparam int SUM_WIDTH = 32;

	// Loop controller states
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FINISH,
		RELEASE
	} fork_state_t;

endpackage

`default_nettype wire

//--- hdl/worker_pkg.sv
`default_nettype none

package worker_pkg;

	// Operand bits walked by the shift-add squarer
	localparam int MUL_WIDTH = 32;

	// Worker states
	typedef enum logic [1:0] {
		IDLE,
		ASK,
		MULT
	} work_state_t;

endpackage

`default_nettype wire

//--- hdl/fork_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fork_ctrl (
	input wire clk,
	input wire rst_n,
	input wire req,
	output logic ack,
	output logic [par_pkg::SUM_WIDTH-1:0] result,
	output logic issue_fork,
	output logic run,
	input wire drained,
	input wire [par_pkg::N_CORE-1:0] ending,
	input wire [par_pkg::N_CORE-1:0][par_pkg::SUM_WIDTH-1:0] part_sum
);

	par_pkg::fork_state_t state;
	logic [par_pkg::SUM_WIDTH-1:0] total;
	logic loop_done;

	// Reduction of the partial sums
	always_comb begin
		logic [par_pkg::SUM_WIDTH-1:0] acc;
		acc = '0;
		for (int i = 0; i < par_pkg::N_CORE; i++) begin
			acc = acc + part_sum[i];
		end
		total = acc;
	end

	// The fork cycle still sees the allocator state of the previous loop,
	// so end detection waits until the new values are loaded
	assign loop_done = (state == par_pkg::RUN) && !issue_fork && drained && (&ending);

	// Workers stop asking once every iteration is handed out
	assign run = (state == par_pkg::RUN) && !drained;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= par_pkg::IDLE;
			ack <= 1'b0;
			issue_fork <= 1'b0;
			result <= '0;
		end else begin
			issue_fork <= 1'b0;
			case (state)
				par_pkg::IDLE, par_pkg::RELEASE: begin
					// Host command sampled here
					if (req) begin
						state <= par_pkg::RUN;
						issue_fork <= 1'b1;
					end else begin
						state <= par_pkg::IDLE;
					end
				end
				par_pkg::RUN: begin
					if (loop_done) begin
						state <= par_pkg::FINISH;
						ack <= 1'b1;
						result <= total;
					end
				end
				par_pkg::FINISH: begin
					// Hold result until the host lets go of req
					if (!req) begin
						state <= par_pkg::RELEASE;
						ack <= 1'b0;
					end
				end
				default: begin
					state <= par_pkg::IDLE;
					ack <= 1'b0;
				end
			endcase
		end
	end

	// ack only comes up when a running loop finishes
	ack_on_finish: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> (state == par_pkg::FINISH) && ($past(state) == par_pkg::RUN)
	);

	// Single-cycle fork pulse
	fork_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		issue_fork |=> !issue_fork
	);

endmodule

`default_nettype wire

//--- hdl/index_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module index_alloc (
	input wire clk,
	input wire rst_n,
	input wire issue_fork,
	input wire signed [par_pkg::IDX_WIDTH-1:0] start,
	input wire signed [par_pkg::IDX_WIDTH-1:0] stride,
	input wire [par_pkg::CNT_WIDTH-1:0] count,
	input wire [par_pkg::N_CORE-1:0] idx_req,
	output logic [par_pkg::N_CORE-1:0] idx_gnt,
	output logic [par_pkg::N_CORE-1:0][par_pkg::IDX_WIDTH-1:0] idx_val,
	output logic drained
);

	logic signed [par_pkg::IDX_WIDTH-1:0] ctr;
	logic signed [par_pkg::IDX_WIDTH-1:0] strd;
	logic [par_pkg::CNT_WIDTH-1:0] remaining;
	logic [par_pkg::CNT_WIDTH-1:0] n_gnt;
	logic signed [par_pkg::IDX_WIDTH-1:0] step;

	// Prefix ranking in core order
	// The k-th granted core gets ctr + k*stride
	always_comb begin
		logic [par_pkg::CNT_WIDTH-1:0] rank;
		logic signed [par_pkg::IDX_WIDTH-1:0] off;
		rank = '0;
		off = '0;
		for (int i = 0; i < par_pkg::N_CORE; i++) begin
			idx_gnt[i] = idx_req[i] && (rank < remaining);
			idx_val[i] = ctr + off;
			if (idx_gnt[i]) begin
				rank = rank + 1'b1;
				off = off + strd;
			end
		end
		n_gnt = rank;
		step = off;
	end

	assign drained = (remaining == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			remaining <= '0;
		end else if (issue_fork) begin
			remaining <= count;
		end else begin
			remaining <= remaining - n_gnt;
		end
	end

	// Loop counter and stride, loaded by each fork
	always_ff @(posedge clk) begin
		if (issue_fork) begin
			ctr <= start;
			strd <= stride;
		end else begin
			ctr <= ctr + step;
		end
	end

	// Never hand out more iterations than are left, so the count never wraps
	gnt_cap: assert property (
		@(posedge clk) disable iff (!rst_n)
		!issue_fork |=> remaining <= $past(remaining)
	);

endmodule

`default_nettype wire

//--- hdl/worker_core.sv
`timescale 1ns/1ps
`default_nettype none

module worker_core (
	input wire clk,
	input wire rst_n,
	input wire issue_fork,
	input wire run,
	output logic idx_req,
	input wire idx_gnt,
	input wire signed [par_pkg::IDX_WIDTH-1:0] idx_val,
	output logic ending,
	output logic [par_pkg::SUM_WIDTH-1:0] part_sum
);

	worker_pkg::work_state_t state;

	// Shift-add datapath
	logic [worker_pkg::MUL_WIDTH-1:0] mag;
	logic [worker_pkg::MUL_WIDTH-1:0] mcand;
	logic [worker_pkg::MUL_WIDTH-1:0] mplier;
	logic [par_pkg::SUM_WIDTH-1:0] prod;
	logic [par_pkg::SUM_WIDTH-1:0] prod_next;
	logic mult_last;

	// Square of a negative index equals square of its magnitude
	assign mag = idx_val[par_pkg::IDX_WIDTH-1] ? -idx_val : idx_val;

	assign prod_next = prod + (mplier[0] ? mcand : '0);

	// Stop once no higher multiplier bit is set
	assign mult_last = (mplier[worker_pkg::MUL_WIDTH-1:1] == '0);

	assign idx_req = (state == worker_pkg::ASK);
	assign ending = (state == worker_pkg::IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= worker_pkg::IDLE;
		end else begin
			case (state)
				worker_pkg::IDLE: begin
					if (issue_fork) begin
						state <= worker_pkg::ASK;
					end
				end
				worker_pkg::ASK: begin
					if (idx_gnt) begin
						state <= worker_pkg::MULT;
					end else if (!run) begin
						// Nothing left to hand out
						state <= worker_pkg::IDLE;
					end
				end
				worker_pkg::MULT: begin
					if (mult_last) begin
						state <= run ? worker_pkg::ASK : worker_pkg::IDLE;
					end
				end
				default: begin
					state <= worker_pkg::IDLE;
				end
			endcase
		end
	end

	// Running sum, cleared by each fork
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			part_sum <= '0;
		end else if (issue_fork) begin
			part_sum <= '0;
		end else if (state == worker_pkg::MULT && mult_last) begin
			part_sum <= part_sum + prod_next;
		end
	end

	always_ff @(posedge clk) begin
		if (state == worker_pkg::ASK && idx_gnt) begin
			mcand <= mag;
			mplier <= mag;
			prod <= '0;
		end else if (state == worker_pkg::MULT) begin
			prod <= prod_next;
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	// The allocator grants only cores that are asking
	gnt_needs_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		idx_gnt |-> idx_req
	);

endmodule

`default_nettype wire

//--- hdl/par_loop_top.sv
`timescale 1ns/1ps
`default_nettype none

module par_loop_top (
	input wire clk,
	input wire rst_n,
	input wire req,
	input wire signed [par_pkg::IDX_WIDTH-1:0] start,
	input wire signed [par_pkg::IDX_WIDTH-1:0] stride,
	input wire [par_pkg::CNT_WIDTH-1:0] count,
	output logic ack,
	output logic [par_pkg::SUM_WIDTH-1:0] result
);

	// Fork control
	logic issue_fork;
	logic run;
	logic drained;

	// Per-core status back to the controller
	logic [par_pkg::N_CORE-1:0] ending;
	logic [par_pkg::N_CORE-1:0][par_pkg::SUM_WIDTH-1:0] part_sum;

	// Iteration requests and grants
	logic [par_pkg::N_CORE-1:0] idx_req;
	logic [par_pkg::N_CORE-1:0] idx_gnt;
	logic [par_pkg::N_CORE-1:0][par_pkg::IDX_WIDTH-1:0] idx_val;

	fork_ctrl fork_ctrl_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.ack(ack),
		.result(result),
		.issue_fork(issue_fork),
		.run(run),
		.drained(drained),
		.ending(ending),
		.part_sum(part_sum)
	);

	// Host command values stay stable while req is high
	index_alloc index_alloc_i (
		.clk(clk),
		.rst_n(rst_n),
		.issue_fork(issue_fork),
		.start(start),
		.stride(stride),
		.count(count),
		.idx_req(idx_req),
		.idx_gnt(idx_gnt),
		.idx_val(idx_val),
		.drained(drained)
	);

	for (genvar i = 0; i < par_pkg::N_CORE; i++) begin : g_worker
		worker_core worker_i (
			.clk(clk),
			.rst_n(rst_n),
			.issue_fork(issue_fork),
			.run(run),
			.idx_req(idx_req[i]),
			.idx_gnt(idx_gnt[i]),
			.idx_val(idx_val[i]),
			.ending(ending[i]),
			.part_sum(part_sum[i])
		);
	end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// Reset held low for the first two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- test/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input wire clk,
	input wire rst_n,
	input wire req,
	input wire ack,
	input wire signed [par_pkg::IDX_WIDTH-1:0] start,
	input wire signed [par_pkg::IDX_WIDTH-1:0] stride,
	input wire [par_pkg::CNT_WIDTH-1:0] count,
	input wire [par_pkg::SUM_WIDTH-1:0] result,
	input wire [31:0] timeouts,
	input wire report,
	output logic [31:0] error_count
);

	logic req_q;
	logic ack_q;
	logic rst_q;
	logic reported;
	logic cmd_valid;
	logic [par_pkg::SUM_WIDTH-1:0] expected;
	logic [par_pkg::SUM_WIDTH-1:0] held;
	int checks;
	int mismatches;
	int proto_errors;

	// Sum of squares of start + i*stride, wrapping at 32 bits
	function automatic logic [31:0] sum_of_squares(input logic [31:0] s, input logic [31:0] d,
		input int n);
		logic [31:0] idx;
		logic [31:0] acc;
		idx = s;
		acc = '0;
		for (int i = 0; i < n; i++) begin
			acc = acc + idx * idx;
			idx = idx + d;
		end
		return acc;
	endfunction

	assign error_count = mismatches + proto_errors;

	initial begin
		req_q = 1'b0;
		ack_q = 1'b0;
		rst_q = 1'b0;
		reported = 1'b0;
		cmd_valid = 1'b0;
		expected = '0;
		held = '0;
		checks = 0;
		mismatches = 0;
		proto_errors = 0;
	end

	always @(posedge clk) begin
		// First edge out of reset
		if (rst_n && !rst_q) begin
			checks++;
			if (ack !== 1'b0) begin
				$display("ERROR: ack is not low after reset, time %0t", $time);
				proto_errors++;
			end
			if (result !== '0) begin
				$display("mismatch at %0t: result expected %0h got %0h", $time, 32'h0, result);
				mismatches++;
			end
		end
		if (rst_n) begin
			// New command from the host
			if (req && !req_q) begin
				if (ack) begin
					$display("ERROR: req rose while ack was still high, time %0t", $time);
					proto_errors++;
				end
				expected = sum_of_squares(start, stride, int'(count));
				cmd_valid = 1'b1;
			end
			if (!req && req_q && !ack) begin
				$display("ERROR: req dropped before ack, time %0t", $time);
				proto_errors++;
			end
			if (ack && !ack_q) begin
				checks++;
				if (!req) begin
					$display("ERROR: ack rose while req was low, time %0t", $time);
					proto_errors++;
				end
				if (!cmd_valid) begin
					$display("ERROR: ack rose with no command pending, time %0t", $time);
					proto_errors++;
				end else if (result !== expected) begin
					$display("mismatch at %0t: result expected %0h got %0h",
						$time, expected, result);
					mismatches++;
				end
				held = result;
				cmd_valid = 1'b0;
			end
			// result must hold for as long as ack does
			if (ack && ack_q && result !== held) begin
				$display("mismatch at %0t: result expected %0h got %0h", $time, held, result);
				mismatches++;
			end
			if (!ack && ack_q && req) begin
				$display("ERROR: ack fell while req was still high, time %0t", $time);
				proto_errors++;
			end
		end
		if (report && !reported) begin
			$display("%0d checks, %0d mismatches, %0d protocol errors, %0d timeouts",
				checks, mismatches, proto_errors, timeouts);
			reported = 1'b1;
		end
		req_q = req;
		ack_q = ack;
		rst_q = rst_n;
	end

endmodule

`default_nettype wire

//--- test/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	localparam int TIMEOUT_CYCLES = 5000;

	logic clk;
	logic rst_n;
	logic req;
	logic signed [par_pkg::IDX_WIDTH-1:0] start;
	logic signed [par_pkg::IDX_WIDTH-1:0] stride;
	logic [par_pkg::CNT_WIDTH-1:0] count;
	logic ack;
	logic [par_pkg::SUM_WIDTH-1:0] result;
	logic report;
	logic [31:0] error_count;
	int timeouts;
	logic timed_out;
	integer seed;

	tb_clock clock_i (
		.clk(clk),
		.rst_n(rst_n)
	);

	par_loop_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.start(start),
		.stride(stride),
		.count(count),
		.ack(ack),
		.result(result)
	);

	tb_checker checker_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.ack(ack),
		.start(start),
		.stride(stride),
		.count(count),
		.result(result),
		.timeouts(timeouts),
		.report(report),
		.error_count(error_count)
	);

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = $random(seed);
		return lo + int'(r % 32'(hi - lo + 1));
	endfunction

	// One four-phase transfer, then an idle gap of gap cycles
	task automatic run_cmd(input int s, input int d, input int n, input int hold,
		input int gap);
		int cycles;
		if (!timed_out) begin
			start <= s;
			stride <= d;
			count <= n[par_pkg::CNT_WIDTH-1:0];
			req <= 1'b1;
			cycles = 0;
			do begin
				@(posedge clk);
				cycles++;
			end while (!ack && cycles < TIMEOUT_CYCLES);
			if (!ack) begin
				$display("ERROR: ack did not rise within %0d cycles, time %0t",
					TIMEOUT_CYCLES, $time);
				timeouts++;
				timed_out = 1'b1;
			end else begin
				repeat (hold) @(posedge clk);
				req <= 1'b0;
				cycles = 0;
				do begin
					@(posedge clk);
					cycles++;
				end while (ack && cycles < TIMEOUT_CYCLES);
				if (ack) begin
					$display("ERROR: ack did not fall within %0d cycles, time %0t",
						TIMEOUT_CYCLES, $time);
					timeouts++;
					timed_out = 1'b1;
				end else begin
					repeat (gap) @(posedge clk);
				end
			end
		end
	endtask

	initial begin
		int cycles;
		int s;
		int d;
		int n;
		int hold;
		int gap;
		seed = 32'h5785_896c;
		req = 1'b0;
		start = '0;
		stride = '0;
		count = '0;
		report = 1'b0;
		timeouts = 0;
		timed_out = 1'b0;

		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!rst_n && cycles < TIMEOUT_CYCLES);
		if (!rst_n) begin
			$display("ERROR: reset was never released");
			timeouts++;
			timed_out = 1'b1;
		end

		// Random loops, req held a few extra cycles after ack
		for (int i = 0; i < 50; i++) begin
			s = rand_range(-1000, 1000);
			d = rand_range(-50, 50);
			n = rand_range(1, 40);
			hold = rand_range(0, 4);
			gap = rand_range(0, 3);
			run_cmd(s, d, n, hold, gap);
		end

		// Empty loops
		s = rand_range(-1000, 1000);
		run_cmd(s, 7, 0, 2, 1);
		run_cmd(0, 0, 0, 0, 0);

		// Zero stride, several cores granted per cycle
		for (int i = 0; i < 6; i++) begin
			s = rand_range(-1000, 1000);
			n = rand_range(5, 40);
			run_cmd(s, 0, n, 0, 1);
		end

		// Back to back, sums must restart on every fork
		for (int i = 0; i < 10; i++) begin
			s = rand_range(-1000, 1000);
			d = rand_range(-50, 50);
			n = rand_range(1, 40);
			run_cmd(s, d, n, 0, 0);
		end

		// Indices near +-2^20, squares wrap at 32 bits
		for (int i = 0; i < 10; i++) begin
			s = (1 << 20) - rand_range(0, 200);
			if (rand_range(0, 1) == 1) begin
				s = -s;
			end
			d = rand_range(-50, 50);
			n = rand_range(1, 40);
			run_cmd(s, d, n, 0, 1);
		end

		report <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		if (error_count == 0 && timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
hdl/par_pkg.sv
hdl/worker_pkg.sv
hdl/fork_ctrl.sv
hdl/index_alloc.sv
hdl/worker_core.sv
hdl/par_loop_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

//--- Makefile
SIM = obj_dir/Vtb_top

.PHONY: run clean

# Rebuilt only when a source or the file list changes
$(SIM): all.f $(wildcard hdl/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f all.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
